//--- sim.f
+incdir+src
src/dcache_pkg.sv
src/flush_counter.sv
src/cache_ways.sv
src/dcache_fsm.sv
src/dcache_top.sv
sim/dcache_assertions.sv
sim/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the dcache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f sim.f --top-module dcache_tb -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/dcache_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sim/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tb;
   import dcache_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 8;
   localparam int N_TXN        = 300;
   localparam int WATCHDOG_NS  = N_TXN * 20 * CLK_PERIOD;
   localparam logic [15:0] SEED = 16'd47290;
   // common upper tag bits of all test addresses
   localparam logic [`DC_TAG_W-3:0] TAG_BASE = 24'h3C5A10;

   logic     CLK = 1'b0;
   logic     nRST;
   logic     req_valid;
   cpu_req_t req;
   logic     halt;
   logic     mem_ready;
   word_t    mem_rdata;
   logic     req_ready;
   word_t    rdata;
   logic     flushed;
   logic     mem_valid;
   mem_req_t mem_req;

   logic [15:0] lfsr;
   word_t       mem_model [word_t];
   word_t       ref_model [64];
   logic        written [64];
   int          checks = 0;
   int          value_errors = 0;
   int          other_errors = 0;
   int          mem_cycles = 0;

   dcache_top dcache_top_i (
      .CLK       (CLK),
      .nRST      (nRST),
      .req_valid (req_valid),
      .req       (req),
      .halt      (halt),
      .mem_ready (mem_ready),
      .mem_rdata (mem_rdata),
      .req_ready (req_ready),
      .rdata     (rdata),
      .flushed   (flushed),
      .mem_valid (mem_valid),
      .mem_req   (mem_req)
   );

   bind dcache_top dcache_assertions dcache_assertions_i (
      .CLK       (CLK),
      .nRST      (nRST),
      .req_ready (req_ready),
      .flushed   (flushed),
      .mem_valid (mem_valid),
      .mem_ready (mem_ready),
      .mem_req   (mem_req)
   );

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int b = 0; b < n; b++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // fill pattern of untouched memory uses every address bit
   function automatic word_t fill_word(input word_t addr);
      return {addr[15:0], addr[31:16]} ^ 32'hC3A5_961E;
   endfunction

   function automatic word_t mem_read(input word_t addr);
      if (mem_model.exists(addr))
      begin
         return mem_model[addr];
      end
      return fill_word(addr);
   endfunction

   // model index is {tag select, set, word}
   function automatic word_t test_addr(input logic [5:0] i);
      dc_addr_t a;
      a.tag    = {TAG_BASE, i[5:4]};
      a.idx    = i[3:1];
      a.blkoff = i[0];
      a.bytoff = '0;
      return word_t'(a);
   endfunction

   function automatic logic [5:0] addr_index(input word_t addr);
      dc_addr_t a;
      a = dc_addr_t'(addr);
      return {a.tag[1:0], a.idx, a.blkoff};
   endfunction

   function automatic logic in_range(input word_t addr);
      dc_addr_t a;
      a = dc_addr_t'(addr);
      return (a.tag[`DC_TAG_W-1:2] == TAG_BASE) && (a.bytoff == '0);
   endfunction

   task automatic check_word(input word_t actual, input word_t expected, input string what);
      checks++;
      if (actual !== expected)
      begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                  $time, what, actual, expected);
      end
   endtask

   task automatic check_mem_req(input mem_req_t actual, input mem_req_t expected,
                                input string what);
      checks++;
      if (actual !== expected)
      begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s, got %h/%h/%b, expected %h/%h/%b", $time, what,
                  actual.addr, actual.wdata, actual.write,
                  expected.addr, expected.wdata, expected.write);
      end
   endtask

   // drive on the falling edge and sample halfway to the rising edge
   task automatic run_cycle(input logic valid, input logic h, input cpu_req_t r,
                            output logic done);
      mem_req_t exp;
      logic [5:0] k;
      @(negedge CLK);
      // memory answers the request that has stood since the rising edge
      mem_rdata = mem_read(mem_req.addr);
      mem_ready = (random_bits(2) != 0);
      req_valid = valid;
      req       = r;
      halt      = h;
      #(CLK_PERIOD / 4);
      done = 1'b0;
      if (mem_valid)
      begin
         mem_cycles++;
      end
      if (mem_valid && mem_ready && !in_range(mem_req.addr))
      begin
         other_errors++;
         $display("memory access at %0t to address %h outside the tested range",
                  $time, mem_req.addr);
      end
      else if (mem_valid && mem_ready && mem_req.write)
      begin
         exp.addr  = mem_req.addr;
         exp.wdata = ref_model[addr_index(mem_req.addr)];
         exp.write = 1'b1;
         check_mem_req(mem_req, exp, $sformatf("memory write to %h", mem_req.addr));
         mem_model[mem_req.addr] = mem_req.wdata;
      end
      if (valid && req_ready)
      begin
         done = 1'b1;
         k    = addr_index(r.addr);
         if (r.write)
         begin
            ref_model[k] = r.wdata;
            written[k]   = 1'b1;
         end
         else
         begin
            check_word(rdata, ref_model[k], $sformatf("read of %h", r.addr));
         end
      end
   endtask

   task automatic do_request(input cpu_req_t r);
      logic done;
      done = 1'b0;
      while (!done)
      begin
         run_cycle(1'b1, 1'b0, r, done);
      end
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: run still busy after %0d ns", WATCHDOG_NS);
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin
      cpu_req_t r;
      cpu_req_t last;
      logic     last_read;
      logic     done;
      int       gap;
      int       mem_before;
      int       assert_errors;
      lfsr      = SEED;
      nRST      = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      halt      = 1'b0;
      mem_ready = 1'b0;
      mem_rdata = '0;
      last      = '0;
      last_read = 1'b0;
      for (int n = 0; n < 64; n++)
      begin
         ref_model[n] = fill_word(test_addr(6'(n)));
         written[n]   = 1'b0;
      end
      repeat (RESET_CYCLES) @(negedge CLK);
      nRST = 1'b1;

      for (int n = 0; n < N_TXN; n++)
      begin
         gap = int'(random_bits(2));
         repeat (gap) run_cycle(1'b0, 1'b0, last, done);
         if (last_read && random_bits(2) == 0)
         begin
            // same address again must hit
            mem_before = mem_cycles;
            do_request(last);
            if (mem_cycles != mem_before)
            begin
               other_errors++;
               $display("repeated read of %h at %0t went to memory", last.addr, $time);
            end
         end
         else
         begin
            r.addr    = test_addr(6'(random_bits(6)));
            r.write   = (random_bits(1) != 0);
            r.wdata   = random_bits(32);
            do_request(r);
            last      = r;
            last_read = !r.write;
         end
      end

      while (!flushed)
      begin
         run_cycle(1'b0, 1'b1, last, done);
      end
      for (int n = 0; n < 64; n++)
      begin
         if (written[n])
         begin
            check_word(mem_read(test_addr(6'(n))), ref_model[n],
                       $sformatf("memory at %h after flush", test_addr(6'(n))));
         end
      end
      // the core gets no answer once the cache is flushed
      repeat (4)
      begin
         run_cycle(1'b1, 1'b0, last, done);
         if (done)
         begin
            other_errors++;
            $display("req_ready was high at %0t after the flush", $time);
         end
      end

      assert_errors = dcache_top_i.dcache_assertions_i.fail_count;
      $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
               checks, value_errors, other_errors, assert_errors);
      if (value_errors + other_errors + assert_errors == 0)
      begin
         $display("*** PASSED ***");
      end
      else
      begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- sim/dcache_assertions.sv
`timescale 1ns/1ps

module dcache_assertions (
   input logic                 CLK,
   input logic                 nRST,
   input logic                 req_ready,
   input logic                 flushed,
   input logic                 mem_valid,
   input logic                 mem_ready,
   input dcache_pkg::mem_req_t mem_req
);

   // failures seen so far
   int fail_count = 0;

   // a stalled memory request keeps address and data
   mem_req_stable_a: assert property (
      @(posedge CLK) disable iff (!nRST)
      (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_req))
   )
   else
   begin
      fail_count++;
      $error("mem_req changed while mem_ready was low");
   end

   flushed_held_a: assert property (
      @(posedge CLK) disable iff (!nRST)
      flushed |=> flushed
   )
   else
   begin
      fail_count++;
      $error("flushed fell before reset");
   end

   // no core transfer once flushed
   ready_after_flush_a: assert property (
      @(posedge CLK) disable iff (!nRST)
      flushed |-> !req_ready
   )
   else
   begin
      fail_count++;
      $error("req_ready high while flushed");
   end

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
   input  logic                 CLK,
   input  logic                 nRST,
   input  logic                 req_valid,
   input  dcache_pkg::cpu_req_t req,
   input  logic                 halt,
   input  logic                 mem_ready,
   input  dcache_pkg::word_t    mem_rdata,
   output logic                 req_ready,
   output dcache_pkg::word_t    rdata,
   output logic                 flushed,
   output logic                 mem_valid,
   output dcache_pkg::mem_req_t mem_req
);

   dcache_pkg::ways_op_t   ways_op;
   dcache_pkg::flush_pos_t pos;
   logic                   flush_step;
   logic                   flush_done;
   logic                   hit;
   logic                   victim_dirty;
   logic                   flush_dirty;

   dcache_fsm fsm_i (
      .CLK          (CLK),
      .nRST         (nRST),
      .req_valid    (req_valid),
      .req_write    (req.write),
      .halt         (halt),
      .hit          (hit),
      .victim_dirty (victim_dirty),
      .flush_dirty  (flush_dirty),
      .flush_done   (flush_done),
      .mem_ready    (mem_ready),
      .req_ready    (req_ready),
      .mem_valid    (mem_valid),
      .ways_op      (ways_op),
      .flush_step   (flush_step),
      .flushed      (flushed)
   );

   // walks the lines during the flush
   flush_counter flush_counter_i (
      .CLK        (CLK),
      .nRST       (nRST),
      .step       (flush_step),
      .line_dirty (flush_dirty),
      .pos        (pos),
      .done       (flush_done)
   );

   cache_ways cache_ways_i (
      .CLK          (CLK),
      .nRST         (nRST),
      .req          (req),
      .op           (ways_op),
      .pos          (pos),
      .mem_rdata    (mem_rdata),
      .hit          (hit),
      .victim_dirty (victim_dirty),
      .flush_dirty  (flush_dirty),
      .rdata        (rdata),
      .mem_req      (mem_req)
   );

endmodule

//--- src/dcache_fsm.sv
`timescale 1ns/1ps

module dcache_fsm (
   input  logic                 CLK,
   input  logic                 nRST,
   input  logic                 req_valid,
   input  logic                 req_write,
   input  logic                 halt,
   input  logic                 hit,
   input  logic                 victim_dirty,
   input  logic                 flush_dirty,
   input  logic                 flush_done,
   input  logic                 mem_ready,
   output logic                 req_ready,
   output logic                 mem_valid,
   output dcache_pkg::ways_op_t ways_op,
   output logic                 flush_step,
   output logic                 flushed
);
   import dcache_pkg::*;

   dc_state_t state;
   dc_state_t next_state;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state <= IDLE;
      end
      else
      begin
         state <= next_state;
      end
   end

   always_comb
   begin
      next_state = state;
      req_ready  = 1'b0;
      mem_valid  = 1'b0;
      ways_op    = OP_NONE;
      flush_step = 1'b0;

      case (state)
         IDLE:
         begin
            // halt wins over anything the core asks for
            if (halt)
            begin
               next_state = FLUSH;
            end
            else if (hit)
            begin
               req_ready = 1'b1;
               if (req_valid && req_write)
               begin
                  ways_op = OP_CPU_WRITE;
               end
            end
            else if (req_valid)
            begin
               next_state = victim_dirty ? WB_FIRST : FILL_FIRST;
            end
         end

         WB_FIRST:
         begin
            mem_valid = 1'b1;
            ways_op   = OP_WB_FIRST;
            if (mem_ready)
            begin
               next_state = WB_SECOND;
            end
         end

         WB_SECOND:
         begin
            mem_valid = 1'b1;
            ways_op   = OP_WB_SECOND;
            if (mem_ready)
            begin
               next_state = FILL_FIRST;
            end
         end

         FILL_FIRST:
         begin
            mem_valid = 1'b1;
            ways_op   = OP_FILL_FIRST;
            if (mem_ready)
            begin
               next_state = FILL_SECOND;
            end
         end

         FILL_SECOND:
         begin
            mem_valid = 1'b1;
            ways_op   = OP_FILL_SECOND;
            // core sees its data together with the last fill word
            req_ready = mem_ready;
            if (mem_ready)
            begin
               next_state = IDLE;
            end
         end

         FLUSH:
         begin
            if (flush_done)
            begin
               next_state = DONE;
            end
            else
            begin
               ways_op   = OP_FLUSH;
               mem_valid = flush_dirty;
               // clean lines are skipped in a single cycle
               flush_step = flush_dirty ? mem_ready : 1'b1;
            end
         end

         DONE:
         begin
            // parked until reset
            next_state = DONE;
         end

         default:
         begin
            next_state = IDLE;
         end
      endcase
   end

   assign flushed = (state == DONE);

endmodule

//--- src/cache_ways.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module cache_ways (
   input  logic                   CLK,
   input  logic                   nRST,
   input  dcache_pkg::cpu_req_t   req,
   input  dcache_pkg::ways_op_t   op,
   input  dcache_pkg::flush_pos_t pos,
   input  dcache_pkg::word_t      mem_rdata,
   output logic                   hit,
   output logic                   victim_dirty,
   output logic                   flush_dirty,
   output dcache_pkg::word_t      rdata,
   output dcache_pkg::mem_req_t   mem_req
);
   import dcache_pkg::*;

   cache_line_t lines [2][`DC_SETS];

   // the way to evict next in each set
   logic [`DC_SETS-1:0] lru;

   dc_addr_t    a;
   logic        hit0;
   logic        hit1;
   logic        hway;
   logic        vway;
   cache_line_t hline;
   cache_line_t victim;
   cache_line_t fline;

   function automatic word_t line_addr(
      input logic [`DC_TAG_W-1:0] tag,
      input logic [`DC_IDX_W-1:0] idx,
      input logic                 blkoff
   );
      dc_addr_t addr;
      addr.tag    = tag;
      addr.idx    = idx;
      addr.blkoff = blkoff;
      addr.bytoff = '0;
      return word_t'(addr);
   endfunction

   assign a = dc_addr_t'(req.addr);

   assign hit0 = lines[0][a.idx].valid && (lines[0][a.idx].tag == a.tag);
   assign hit1 = lines[1][a.idx].valid && (lines[1][a.idx].tag == a.tag);
   assign hit  = hit0 || hit1;
   assign hway = hit1;

   assign vway   = lru[a.idx];
   assign hline  = lines[hway][a.idx];
   assign victim = lines[vway][a.idx];
   assign fline  = lines[pos.way][pos.idx];

   assign victim_dirty = victim.valid && victim.dirty;
   assign flush_dirty  = fline.valid && fline.dirty;

   // a write returns the merged word, a read the stored one
   assign rdata = req.write ? req.wdata : hline.data[a.blkoff];

   always_comb
   begin
      mem_req = '0;
      case (op)
         OP_WB_FIRST, OP_WB_SECOND:
         begin
            mem_req.addr  = line_addr(victim.tag, a.idx, op == OP_WB_SECOND);
            mem_req.wdata = victim.data[op == OP_WB_SECOND];
            mem_req.write = 1'b1;
         end
         OP_FILL_FIRST:
         begin
            mem_req.addr = line_addr(a.tag, a.idx, a.blkoff);
         end
         OP_FILL_SECOND:
         begin
            // partner word of the same block
            mem_req.addr = line_addr(a.tag, a.idx, !a.blkoff);
         end
         OP_FLUSH:
         begin
            mem_req.addr  = line_addr(fline.tag, pos.idx, pos.word);
            mem_req.wdata = fline.data[pos.word];
            mem_req.write = 1'b1;
         end
         default:
         begin
            mem_req = '0;
         end
      endcase
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         lru <= '0;
         for (int w = 0; w < 2; w++)
         begin
            for (int s = 0; s < `DC_SETS; s++)
            begin
               lines[w][s] <= '0;
            end
         end
      end
      else
      begin
         case (op)
            OP_CPU_WRITE:
            begin
               lines[hway][a.idx].data[a.blkoff] <= req.wdata;
               lines[hway][a.idx].dirty          <= 1'b1;
               lru[a.idx]                        <= !hway;
            end
            OP_FILL_FIRST:
            begin
               // victim way takes the new tag and the requested word
               lines[vway][a.idx].valid          <= 1'b1;
               lines[vway][a.idx].dirty          <= 1'b0;
               lines[vway][a.idx].tag            <= a.tag;
               lines[vway][a.idx].data[a.blkoff] <= mem_rdata;
            end
            OP_FILL_SECOND:
            begin
               // the way filled in FILL_FIRST already hits here
               lines[hway][a.idx].data[!a.blkoff] <= mem_rdata;
               lines[hway][a.idx].dirty           <= req.write;
               if (req.write)
               begin
                  lines[hway][a.idx].data[a.blkoff] <= req.wdata;
               end
               lru[a.idx] <= !hway;
            end
            default:
            begin
               lru <= lru;
            end
         endcase
      end
   end

endmodule

//--- src/flush_counter.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module flush_counter (
   input  logic                   CLK,
   input  logic                   nRST,
   input  logic                   step,
   input  logic                   line_dirty,
   output dcache_pkg::flush_pos_t pos,
   output logic                   done
);
   import dcache_pkg::*;

   // {carry, way, idx} of the next line where carry out means all lines seen
   logic [`DC_IDX_W+1:0] line_next;
   logic                 next_line;

   assign line_next = {1'b0, pos.way, pos.idx} + 1'b1;

   // clean lines skip both words and dirty lines move on after word 1
   assign next_line = !line_dirty || pos.word;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         pos  <= '0;
         done <= 1'b0;
      end
      else if (step && !done)
      begin
         if (next_line)
         begin
            pos.word <= 1'b0;
            pos.idx  <= line_next[`DC_IDX_W-1:0];
            pos.way  <= line_next[`DC_IDX_W];
            done     <= line_next[`DC_IDX_W+1];
         end
         else
         begin
            pos.word <= 1'b1;
         end
      end
   end

endmodule

//--- src/dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

   typedef logic [`DC_WORD_W-1:0] word_t;

   // address fields with msb first
   typedef struct packed {
      logic [`DC_TAG_W-1:0]  tag;
      logic [`DC_IDX_W-1:0]  idx;
      logic                  blkoff;
      logic [`DC_BYTE_W-1:0] bytoff;
   } dc_addr_t;

   // one block of two words
   typedef struct packed {
      logic                 valid;
      logic                 dirty;
      logic [`DC_TAG_W-1:0] tag;
      word_t [1:0]          data;
   } cache_line_t;

   typedef struct packed {
      word_t addr;
      word_t wdata;
      logic  write;
   } cpu_req_t;

   // same layout as the cpu request for the memory side
   typedef struct packed {
      word_t addr;
      word_t wdata;
      logic  write;
   } mem_req_t;

   typedef struct packed {
      logic                 way;
      logic [`DC_IDX_W-1:0] idx;
      logic                 word;
   } flush_pos_t;

   typedef enum logic [2:0] {
      OP_NONE,
      OP_CPU_WRITE,
      OP_WB_FIRST,
      OP_WB_SECOND,
      OP_FILL_FIRST,
      OP_FILL_SECOND,
      OP_FLUSH
   } ways_op_t;

   typedef enum logic [2:0] {
      IDLE,
      WB_FIRST,
      WB_SECOND,
      FILL_FIRST,
      FILL_SECOND,
      FLUSH,
      DONE
   } dc_state_t;

endpackage

//--- src/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// word and address width
`define DC_WORD_W 32

// two ways of 8 sets each
`define DC_SETS 8

// set index bits
`define DC_IDX_W 3

// tag is what is left above index, block offset and byte offset
`define DC_TAG_W 26

// byte offset inside a word
`define DC_BYTE_W 2

`endif
